// File: hdl/charlie_framebuf.sv
`timescale 1ns/100ps
`default_nettype none

`include "charlie_params.svh"

module charlie_framebuf (
	input wire wbs_clk_i,
	input wire wbs_rst_i,

	// write port from the bus slave
	input wire we_i,
	input wire charlie_pkg::row_t wr_row_i,
	input wire charlie_pkg::pixrow_t wr_data_i,

	// read port for the bus readback
	input wire charlie_pkg::row_t bus_row_i,
	output charlie_pkg::pixrow_t bus_data_o,

	// read port for the scanner
	input wire charlie_pkg::row_t scan_row_i,
	output charlie_pkg::pixrow_t scan_data_o
);

	// five rows of seven pixels
	charlie_pkg::pixrow_t mem_q [`CHARLIE_ROWS];

	// single write port, clears the whole frame on reset
	always_ff @(posedge wbs_clk_i) begin
		if (wbs_rst_i) begin
			for (int r = 0; r < `CHARLIE_ROWS; r++) begin
				mem_q[r] <= '0;
			end
		end else if (we_i) begin
			mem_q[wr_row_i] <= wr_data_i;
		end
	end

	// combinational reads
	// row indexes past the last row return a dark row
	always_comb begin
		bus_data_o = '0;
		if (bus_row_i < `CHARLIE_ROWS) begin
			bus_data_o = mem_q[bus_row_i];
		end
	end

	always_comb begin
		scan_data_o = '0;
		if (scan_row_i < `CHARLIE_ROWS) begin
			scan_data_o = mem_q[scan_row_i];
		end
	end

	// the bus slave only steers writes to existing rows
	a_wr_row_in_range: assert property (
		@(posedge wbs_clk_i) disable iff (wbs_rst_i)
		we_i |-> (wr_row_i < `CHARLIE_ROWS)
	);

endmodule

`default_nettype wire

// File: hdl/charlie_params.svh
`ifndef CHARLIE_PARAMS_SVH
`define CHARLIE_PARAMS_SVH

// matrix geometry
// five rows are scanned per column, seven columns per frame
`define CHARLIE_ROWS 5
`define CHARLIE_COLS 7

// charlieplexing drives cols*rows pixels from this many pins
// one pin per column, rows share the same seven pins
`define CHARLIE_PINS 7

// pixel step rate in hz
// one pixel slot per tick, 35 ticks per full frame
`define CHARLIE_REFRESH_HZ 100000

// wishbone word address of the control register
// rows live at word addresses 0 to 4 just below it
`define CHARLIE_ADR_CTRL 5

`endif

// File: hdl/charlie_pkg.sv
`default_nettype none

package charlie_pkg;

`include "charlie_params.svh"

	// row index into the frame buffer
	// wide enough for rows 0 to 4, values 5 to 7 are never stored
	typedef logic [$clog2(`CHARLIE_ROWS)-1:0] row_t;

	// column index of the scan cursor
	typedef logic [$clog2(`CHARLIE_COLS)-1:0] col_t;

	// one row of pixels
	// bit n is column n, a set bit lights the pixel
	typedef logic [`CHARLIE_COLS-1:0] pixrow_t;

	// tri-state pin vector
	// same shape for the pin values and the output enables
	typedef logic [`CHARLIE_PINS-1:0] pins_t;

	// wishbone word address
	// 16 words decoded, only 0 to 5 are mapped
	typedef logic [3:0] adr_t;

endpackage

`default_nettype wire

// File: hdl/charlie_scan.sv
`timescale 1ns/100ps
`default_nettype none

`include "charlie_params.svh"

module charlie_scan #(
	parameter int WB_CLK_HZ = 12_000_000
) (
	input wire wbs_clk_i,
	input wire wbs_rst_i,

	// matrix enable from the control register
	input wire en_i,

	// pixels of the row under the cursor, from the frame buffer
	input wire charlie_pkg::pixrow_t row_data_i,
	output charlie_pkg::row_t row_o,

	// pin values and output enables for the pads
	output charlie_pkg::pins_t charlie7x5_o,
	output charlie_pkg::pins_t charlie7x5_oe
);

	// bus clocks per pixel tick
	// the clock is at least twice the refresh rate so this is 2 or more
	localparam int DIV = WB_CLK_HZ / `CHARLIE_REFRESH_HZ;
	localparam int CNT_W = $clog2(DIV);

	// divider
	logic [CNT_W-1:0] div_q;
	logic tick;

	// cursor for the pixel slot being shown
	charlie_pkg::row_t row_q;
	charlie_pkg::col_t col_q;

	// current pixel lit and allowed to show
	logic lit;

	// pins for the cursor
	charlie_pkg::col_t col_pin;
	charlie_pkg::col_t row_pin;
	charlie_pkg::col_t row_p1;

	assign tick = (div_q == CNT_W'(DIV - 1));

	// count 0 to DIV-1, tick on the last count
	always_ff @(posedge wbs_clk_i) begin
		if (wbs_rst_i) begin
			div_q <= '0;
		end else if (tick) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	// rows step every tick
	// columns step when the row wraps, 35 ticks per frame
	always_ff @(posedge wbs_clk_i) begin
		if (wbs_rst_i) begin
			row_q <= '0;
			col_q <= '0;
		end else if (tick) begin
			if (row_q == charlie_pkg::row_t'(`CHARLIE_ROWS - 1)) begin
				row_q <= '0;
				if (col_q == charlie_pkg::col_t'(`CHARLIE_COLS - 1)) begin
					col_q <= '0;
				end else begin
					col_q <= col_q + 1'b1;
				end
			end else begin
				row_q <= row_q + 1'b1;
			end
		end
	end

	// frame buffer reads the row under the cursor
	assign row_o = row_q;

	// pick the pixel, blank when disabled
	assign lit = row_data_i[col_q] && en_i;

	// column owns the pin of the same index
	assign col_pin = col_q;

	// row pin skips over the column pin
	// below it the row shifts by one, at or above it by two
	assign row_p1 = charlie_pkg::col_t'(row_q) + 1'b1;
	assign row_pin = (row_p1 < col_q) ? row_p1 : row_p1 + 1'b1;

	// drive the row pin high and sink through the column pin
	// everything else floats
	always_comb begin
		charlie7x5_o = '0;
		charlie7x5_oe = '0;
		if (lit) begin
			charlie7x5_o = charlie_pkg::pins_t'(1) << row_pin;
			charlie7x5_oe = (charlie_pkg::pins_t'(1) << row_pin)
				| (charlie_pkg::pins_t'(1) << col_pin);
		end
	end

	// a pin is only driven high if its driver is on
	// a lit pixel needs two distinct driven pins, so the row pin never lands on the column
	a_val_within_oe: assert property (
		@(posedge wbs_clk_i) disable iff (wbs_rst_i)
		((charlie7x5_o & ~charlie7x5_oe) == '0)
			&& (!lit || $countones(charlie7x5_oe) == 2)
	);

	// never more than one source pin at a time
	// a lit pixel always finds its source pin on the matrix
	a_val_onehot0: assert property (
		@(posedge wbs_clk_i) disable iff (wbs_rst_i)
		$onehot0(charlie7x5_o) && (lit == (charlie7x5_o != '0))
	);

endmodule

`default_nettype wire

// File: hdl/wbs_charlie7x5.sv
`timescale 1ns/100ps
`default_nettype none

module wbs_charlie7x5 #(
	parameter int WB_CLK_HZ = 12_000_000
) (
	input wire wbs_clk_i,
	input wire wbs_rst_i,

	// wishbone b4 pipelined
	input wire wbs_cyc_i,
	input wire wbs_stb_i,
	input wire wbs_we_i,
	input wire charlie_pkg::adr_t wbs_adr_i,
	input wire [3:0] wbs_sel_i,
	input wire [31:0] wbs_dat_i,
	output wire [31:0] wbs_dat_o,
	output wire wbs_ack_o,
	output wire wbs_stall_o,

	// charlieplexed matrix pins
	// pad tri-state buffers live outside
	output wire charlie_pkg::pins_t charlie7x5_o,
	output wire charlie_pkg::pins_t charlie7x5_oe
);

	// bus slave to frame buffer
	wire fb_we;
	charlie_pkg::row_t fb_row;
	charlie_pkg::pixrow_t fb_wr_data;
	charlie_pkg::pixrow_t fb_rd_data;

	// scanner to frame buffer
	charlie_pkg::row_t scan_row;
	charlie_pkg::pixrow_t scan_data;

	// control enable
	wire scan_en;

	wbs_charlie_regs regs_i (
		.wbs_clk_i (wbs_clk_i),
		.wbs_rst_i (wbs_rst_i),
		.wbs_cyc_i (wbs_cyc_i),
		.wbs_stb_i (wbs_stb_i),
		.wbs_we_i (wbs_we_i),
		.wbs_adr_i (wbs_adr_i),
		.wbs_sel_i (wbs_sel_i),
		.wbs_dat_i (wbs_dat_i),
		.wbs_dat_o (wbs_dat_o),
		.wbs_ack_o (wbs_ack_o),
		.wbs_stall_o (wbs_stall_o),
		.fb_we_o (fb_we),
		.fb_row_o (fb_row),
		.fb_wr_data_o (fb_wr_data),
		.fb_rd_data_i (fb_rd_data),
		.scan_en_o (scan_en)
	);

	// bus readback and scanner share the same pixel store
	charlie_framebuf framebuf_i (
		.wbs_clk_i (wbs_clk_i),
		.wbs_rst_i (wbs_rst_i),
		.we_i (fb_we),
		.wr_row_i (fb_row),
		.wr_data_i (fb_wr_data),
		.bus_row_i (fb_row),
		.bus_data_o (fb_rd_data),
		.scan_row_i (scan_row),
		.scan_data_o (scan_data)
	);

	charlie_scan #(
		.WB_CLK_HZ (WB_CLK_HZ)
	) scan_i (
		.wbs_clk_i (wbs_clk_i),
		.wbs_rst_i (wbs_rst_i),
		.en_i (scan_en),
		.row_data_i (scan_data),
		.row_o (scan_row),
		.charlie7x5_o (charlie7x5_o),
		.charlie7x5_oe (charlie7x5_oe)
	);

endmodule

`default_nettype wire

// File: hdl/wbs_charlie_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "charlie_params.svh"

module wbs_charlie_regs (
	input wire wbs_clk_i,
	input wire wbs_rst_i,

	// wishbone b4 pipelined slave
	input wire wbs_cyc_i,
	input wire wbs_stb_i,
	input wire wbs_we_i,
	input wire charlie_pkg::adr_t wbs_adr_i,
	input wire [3:0] wbs_sel_i,
	input wire [31:0] wbs_dat_i,
	output logic [31:0] wbs_dat_o,
	output logic wbs_ack_o,
	output logic wbs_stall_o,

	// frame buffer write port and bus-side read port
	output logic fb_we_o,
	output charlie_pkg::row_t fb_row_o,
	output charlie_pkg::pixrow_t fb_wr_data_o,
	input wire charlie_pkg::pixrow_t fb_rd_data_i,

	// level enable to the scanner
	output logic scan_en_o
);

	// request when both strobes are high
	logic req;
	// address decode
	logic adr_is_row;
	logic adr_is_ctrl;
	// write qualified by sel bit 0, the only byte lane in use
	logic wr;
	// readback word for the current address
	logic [31:0] rd_word;
	// control register, bit 0 of address 5
	logic ctrl_en_q;

	assign req = wbs_cyc_i && wbs_stb_i;
	assign adr_is_row = (wbs_adr_i < `CHARLIE_ROWS);
	assign adr_is_ctrl = (wbs_adr_i == `CHARLIE_ADR_CTRL);
	assign wr = req && wbs_we_i && wbs_sel_i[0];

	// every access completes in one cycle, never stall
	assign wbs_stall_o = 1'b0;

	// frame buffer writes land on the edge that raises ack
	assign fb_we_o = wr && adr_is_row;
	assign fb_wr_data_o = wbs_dat_i[`CHARLIE_COLS-1:0];

	// the same row index addresses the write and the readback
	// aliasing above row 4 is harmless since adr_is_row gates both
	assign fb_row_o = wbs_adr_i[$bits(charlie_pkg::row_t)-1:0];

	assign scan_en_o = ctrl_en_q;

	// pick the word a read returns
	// unused bits and unmapped addresses read zero
	always_comb begin
		rd_word = '0;
		if (adr_is_row) begin
			rd_word[`CHARLIE_COLS-1:0] = fb_rd_data_i;
		end else if (adr_is_ctrl) begin
			rd_word[0] = ctrl_en_q;
		end
	end

	// ack one cycle after each request, back to back if pipelined
	always_ff @(posedge wbs_clk_i) begin
		if (wbs_rst_i) begin
			wbs_ack_o <= 1'b0;
		end else begin
			wbs_ack_o <= req;
		end
	end

	// registered readback
	// writes return zero, reads the addressed register
	always_ff @(posedge wbs_clk_i) begin
		if (wbs_rst_i) begin
			wbs_dat_o <= '0;
		end else if (req) begin
			wbs_dat_o <= wbs_we_i ? '0 : rd_word;
		end
	end

	// control register, comes out of reset with the matrix enabled
	always_ff @(posedge wbs_clk_i) begin
		if (wbs_rst_i) begin
			ctrl_en_q <= 1'b1;
		end else if (wr && adr_is_ctrl) begin
			ctrl_en_q <= wbs_dat_i[0];
		end
	end

	// an ack is only ever the answer to the previous cycle's request
	a_ack_after_req: assert property (
		@(posedge wbs_clk_i) disable iff (wbs_rst_i)
		wbs_ack_o |-> $past(req)
	);

	// a buffer write only reaches the row named by a row address
	a_fb_we_row_only: assert property (
		@(posedge wbs_clk_i) disable iff (wbs_rst_i)
		fb_we_o |-> (wbs_adr_i < `CHARLIE_ROWS)
			&& (charlie_pkg::adr_t'(fb_row_o) == wbs_adr_i)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the charlieplex matrix testbench with verilator
# exits nonzero if the build or the run fails, or if the log reports a failure

set -u
cd "$(dirname "$0")" || exit 1

top=tb_wbs_charlie7x5
obj_dir=build
log=sim.log

verilator --binary --timing --assert --top-module "$top" \
	-f wbs_charlie7x5.f --Mdir "$obj_dir" -o "$top"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj_dir/$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$log"; then
	echo "failure reported in $log"
	exit 1
fi

echo "no failure reported in $log"
exit 0

// File: tb/charlie_tb_tasks.svh
`ifndef CHARLIE_TB_TASKS_SVH
`define CHARLIE_TB_TASKS_SVH

// bus word compare, used for readback
task automatic check_data(input string what, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0t ns: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp);
	end
endtask

// pin vector compare
task automatic check_pins(input string what, input charlie_pkg::pins_t got,
		input charlie_pkg::pins_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0t ns: %s are %b, expected %b", $time, what, got, exp);
	end
endtask

// pixel row compare, bit n is column n
task automatic check_frame(input string what, input charlie_pkg::pixrow_t got,
		input charlie_pkg::pixrow_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0t ns: %s are %b, expected %b", $time, what, got, exp);
	end
endtask

// one single request, ack expected one edge later and for one cycle only
task automatic bus_cycle(input charlie_pkg::adr_t adr, input logic we, input logic [3:0] sel,
		input logic [31:0] dat, output logic [31:0] rdata);
	int waited;
	@(posedge wbs_clk_i);
	wbs_cyc_i <= 1'b1;
	wbs_stb_i <= 1'b1;
	wbs_we_i <= we;
	wbs_adr_i <= adr;
	wbs_sel_i <= sel;
	wbs_dat_i <= dat;
	// request taken on this edge
	@(posedge wbs_clk_i);
	wbs_cyc_i <= 1'b0;
	wbs_stb_i <= 1'b0;
	waited = 0;
	@(negedge wbs_clk_i);
	while (wbs_ack_o !== 1'b1 && waited < ACK_TIMEOUT) begin
		@(negedge wbs_clk_i);
		waited++;
	end
	checks++;
	if (wbs_ack_o !== 1'b1) begin
		errors++;
		$display("request to address %0d was never acknowledged", adr);
	end else if (waited != 0) begin
		errors++;
		$display("error at %0t ns: ack for address %0d came %0d cycles late", $time, adr, waited);
	end
	rdata = wbs_dat_o;
	@(negedge wbs_clk_i);
	checks++;
	if (wbs_ack_o !== 1'b0) begin
		errors++;
		$display("ack for address %0d lasted more than one cycle", adr);
	end
endtask

// pipelined read of all rows, one request per cycle
task automatic burst_read;
	@(posedge wbs_clk_i);
	wbs_cyc_i <= 1'b1;
	wbs_stb_i <= 1'b1;
	wbs_we_i <= 1'b0;
	wbs_sel_i <= 4'hf;
	wbs_adr_i <= '0;
	for (int i = 0; i < `CHARLIE_ROWS; i++) begin
		@(posedge wbs_clk_i);
		// beat i taken here, queue the next address or end the burst
		if (i < `CHARLIE_ROWS - 1) begin
			wbs_adr_i <= charlie_pkg::adr_t'(i + 1);
		end else begin
			wbs_cyc_i <= 1'b0;
			wbs_stb_i <= 1'b0;
		end
		@(negedge wbs_clk_i);
		checks++;
		if (wbs_ack_o !== 1'b1) begin
			errors++;
			$display("burst beat %0d was not acknowledged on the next edge", i);
		end
		burst_data[i] = wbs_dat_o;
	end
	@(negedge wbs_clk_i);
	checks++;
	if (wbs_ack_o !== 1'b0) begin
		errors++;
		$display("ack kept going after the burst ended");
	end
endtask

`endif

// File: tb/tb_wbs_charlie7x5.sv
`timescale 1ns/100ps
`default_nettype none

`include "charlie_params.svh"

module tb_wbs_charlie7x5;

	// 400 khz bus clock gives a pixel tick every four cycles
	localparam int CLK_HZ = 400000;
	localparam int TICK_CYCLES = CLK_HZ / `CHARLIE_REFRESH_HZ;
	localparam int FRAME_CYCLES = TICK_CYCLES * `CHARLIE_ROWS * `CHARLIE_COLS;
	localparam int ACK_TIMEOUT = 8;
	localparam int N_STIM = 18;

	// one table entry, exp only checked on reads
	typedef struct packed {
		charlie_pkg::adr_t adr;
		logic we;
		logic [3:0] sel;
		logic [31:0] dat;
		logic [31:0] exp;
	} stim_t;

	logic wbs_clk_i;
	logic wbs_rst_i;
	logic wbs_cyc_i;
	logic wbs_stb_i;
	logic wbs_we_i;
	charlie_pkg::adr_t wbs_adr_i;
	logic [3:0] wbs_sel_i;
	logic [31:0] wbs_dat_i;
	wire [31:0] wbs_dat_o;
	wire wbs_ack_o;
	wire wbs_stall_o;
	wire charlie_pkg::pins_t charlie7x5_o;
	wire charlie_pkg::pins_t charlie7x5_oe;

	stim_t stim [N_STIM];
	logic [31:0] burst_data [`CHARLIE_ROWS];
	charlie_pkg::pixrow_t frame [`CHARLIE_ROWS];
	// pixels decoded from the pins while watch is set
	charlie_pkg::pixrow_t seen [`CHARLIE_ROWS];
	logic watch;
	int seed;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed = 0;

	`include "charlie_tb_tasks.svh"

	wbs_charlie7x5 #(
		.WB_CLK_HZ (CLK_HZ)
	) dut_i (
		.wbs_clk_i (wbs_clk_i),
		.wbs_rst_i (wbs_rst_i),
		.wbs_cyc_i (wbs_cyc_i),
		.wbs_stb_i (wbs_stb_i),
		.wbs_we_i (wbs_we_i),
		.wbs_adr_i (wbs_adr_i),
		.wbs_sel_i (wbs_sel_i),
		.wbs_dat_i (wbs_dat_i),
		.wbs_dat_o (wbs_dat_o),
		.wbs_ack_o (wbs_ack_o),
		.wbs_stall_o (wbs_stall_o),
		.charlie7x5_o (charlie7x5_o),
		.charlie7x5_oe (charlie7x5_oe)
	);

	initial begin
		wbs_clk_i = 1'b0;
		forever #4 wbs_clk_i = ~wbs_clk_i;
	end

	// hard stop in case a wait never ends
	initial begin
		#100000;
		$display("timeout: simulation ran past its time limit");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// pin monitor
	// legality of every pin state, then inverse pin rule back to row and column
	always @(negedge wbs_clk_i) begin : pin_monitor
		int rp;
		int cp;
		int row;
		if (!wbs_rst_i) begin
			if (wbs_stall_o !== 1'b0) begin
				errors++;
				$display("error at %0t ns: stall went high", $time);
			end
			if (charlie7x5_o != '0 || charlie7x5_oe != '0) begin
				rp = -1;
				cp = -1;
				for (int p = 0; p < `CHARLIE_PINS; p++) begin
					if (charlie7x5_o[p]) rp = p;
					else if (charlie7x5_oe[p]) cp = p;
				end
				// row pin is row+1 below the column pin, row+2 above it
				row = (rp < cp) ? rp - 1 : rp - 2;
				if ($countones(charlie7x5_oe) != 2 || $countones(charlie7x5_o) != 1
						|| (charlie7x5_o & ~charlie7x5_oe) != '0
						|| row < 0 || row >= `CHARLIE_ROWS) begin
					errors++;
					$display("error at %0t ns: illegal pin state, value %b enable %b",
						$time, charlie7x5_o, charlie7x5_oe);
				end else if (watch) begin
					seen[row][cp] = 1'b1;
				end
			end
		end
	end

	// watch the pins for one full frame
	task automatic scan_window;
		int cycles;
		@(posedge wbs_clk_i);
		for (int r = 0; r < `CHARLIE_ROWS; r++) begin
			seen[r] = '0;
		end
		watch = 1'b1;
		cycles = 0;
		while (cycles < FRAME_CYCLES) begin
			@(posedge wbs_clk_i);
			cycles++;
		end
		watch = 1'b0;
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	initial begin
		int err0;
		int cycles;
		logic [31:0] rd;
		wbs_rst_i = 1'b1;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i = 1'b0;
		wbs_adr_i = '0;
		wbs_sel_i = '0;
		wbs_dat_i = '0;
		watch = 1'b0;
		seed = 32'hc26f;
		// rows keep the low seven bits, sel bit 0 gates writes, unmapped reads zero
		stim[0] = '{4'd0, 1'b1, 4'h1, 32'hffff_ffff, 32'h0};
		stim[1] = '{4'd0, 1'b0, 4'hf, 32'h0, 32'h7f};
		stim[2] = '{4'd1, 1'b1, 4'hf, 32'h55, 32'h0};
		stim[3] = '{4'd1, 1'b0, 4'hf, 32'h0, 32'h55};
		stim[4] = '{4'd2, 1'b1, 4'h1, 32'hab, 32'h0};
		stim[5] = '{4'd2, 1'b0, 4'hf, 32'h0, 32'h2b};
		stim[6] = '{4'd2, 1'b1, 4'h2, 32'h11, 32'h0};
		stim[7] = '{4'd2, 1'b0, 4'hf, 32'h0, 32'h2b};
		stim[8] = '{4'd4, 1'b1, 4'h1, 32'h3c, 32'h0};
		stim[9] = '{4'd4, 1'b0, 4'hf, 32'h0, 32'h3c};
		stim[10] = '{4'd3, 1'b0, 4'hf, 32'h0, 32'h0};
		stim[11] = '{4'd6, 1'b0, 4'hf, 32'h0, 32'h0};
		stim[12] = '{4'd9, 1'b1, 4'h1, 32'hff, 32'h0};
		stim[13] = '{4'd9, 1'b0, 4'hf, 32'h0, 32'h0};
		// address 9 shares its low bits with row 1, which must keep its value
		stim[14] = '{4'd1, 1'b0, 4'hf, 32'h0, 32'h55};
		stim[15] = '{4'd5, 1'b0, 4'hf, 32'h0, 32'h1};
		stim[16] = '{4'd5, 1'b1, 4'h2, 32'h0, 32'h0};
		stim[17] = '{4'd5, 1'b0, 4'hf, 32'h0, 32'h1};
		repeat (10) @(posedge wbs_clk_i);
		wbs_rst_i <= 1'b0;

		err0 = errors;
		for (int i = 0; i < N_STIM; i++) begin
			bus_cycle(stim[i].adr, stim[i].we, stim[i].sel, stim[i].dat, rd);
			if (!stim[i].we) begin
				check_data($sformatf("read of address %0d", stim[i].adr), rd, stim[i].exp);
			end
		end
		end_test("register table", err0);

		// random junk above the pixel bits must not reach the buffer
		err0 = errors;
		for (int r = 0; r < `CHARLIE_ROWS; r++) begin
			frame[r] = charlie_pkg::pixrow_t'($random(seed));
			bus_cycle(charlie_pkg::adr_t'(r), 1'b1, 4'h1,
				({$random(seed)} & 32'hffff_ff80) | 32'(frame[r]), rd);
		end
		burst_read();
		for (int r = 0; r < `CHARLIE_ROWS; r++) begin
			check_data($sformatf("burst read of row %0d", r), burst_data[r], 32'(frame[r]));
		end
		end_test("burst readback", err0);

		err0 = errors;
		scan_window();
		for (int r = 0; r < `CHARLIE_ROWS; r++) begin
			check_frame($sformatf("pixels seen in row %0d", r), seen[r], frame[r]);
		end
		end_test("frame scan", err0);

		// blank the matrix for a whole frame
		err0 = errors;
		bus_cycle(charlie_pkg::adr_t'(`CHARLIE_ADR_CTRL), 1'b1, 4'h1, 32'h0, rd);
		cycles = 0;
		while (cycles < FRAME_CYCLES) begin
			@(negedge wbs_clk_i);
			check_pins("pin values while disabled", charlie7x5_o, '0);
			check_pins("output enables while disabled", charlie7x5_oe, '0);
			cycles++;
		end
		end_test("blanking", err0);

		err0 = errors;
		bus_cycle(charlie_pkg::adr_t'(`CHARLIE_ADR_CTRL), 1'b1, 4'h1, 32'h1, rd);
		scan_window();
		for (int r = 0; r < `CHARLIE_ROWS; r++) begin
			check_frame($sformatf("pixels seen in row %0d", r), seen[r], frame[r]);
		end
		end_test("re-enable scan", err0);

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: wbs_charlie7x5.f
+incdir+hdl
+incdir+tb
hdl/charlie_pkg.sv
hdl/charlie_framebuf.sv
hdl/wbs_charlie_regs.sv
hdl/charlie_scan.sv
hdl/wbs_charlie7x5.sv
tb/tb_wbs_charlie7x5.sv
